// ==== servo_translator.f ====
+incdir+test
rtl/servo_pkg.sv
rtl/move_pkg.sv
rtl/move_fetch.sv
rtl/move_sequencer.sv
rtl/servo_pwm.sv
rtl/servo_translator.sv
test/tb_servo_translator.sv

// ==== Bender.yml ====
package:
  name: servo_translator

sources:
  - files:
      - rtl/servo_pkg.sv
      - rtl/move_pkg.sv
      - rtl/move_fetch.sv
      - rtl/move_sequencer.sv
      - rtl/servo_pwm.sv
      - rtl/servo_translator.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_servo_translator.sv

// ==== test/tb_servo_model.svh ====
`ifndef TB_SERVO_MODEL_SVH
`define TB_SERVO_MODEL_SVH

// position after one step of a quarter turn, face 0 to 3 is left, right, down, up
function automatic servo_pos_t next_position(int face, int step, servo_pos_t pos);
	servo_pos_t p;
	int arm;
	int wrist;
	int cross0;
	int cross1;
	p = pos;
	arm = face == 0 ? SLIDE_L : face == 1 ? SLIDE_R : face == 2 ? SLIDE_B : SLIDE_T;
	wrist = face == 0 ? WRIST_L : face == 1 ? WRIST_R : face == 2 ? WRIST_B : WRIST_T;
	// left and right turn between top and bottom
	cross0 = (face < 2) ? SLIDE_T : SLIDE_L;
	cross1 = (face < 2) ? SLIDE_B : SLIDE_R;
	if (step == 0 || step == 2) begin
		// crossing arms out of the way, then back
		p[cross0] = (step == 2);
		p[cross1] = (step == 2);
	end else if (step == 1 || step == 4) begin
		p[wrist] = (step == 1);
	end else begin
		// turning arm lets go so its wrist can return
		p[arm] = (step == 5);
	end
	return p;
endfunction

function automatic int pulse_width_for(logic bit_val);
	return bit_val ? PULSE_HIGH : PULSE_LOW;
endfunction

// two codes per face, odd one is the prime move
function automatic int face_of_code(logic [3:0] code);
	return int'(code[2:1]);
endfunction

function automatic int steps_in_code(logic [3:0] code);
	if (code > 4'd7) begin
		return 0;
	end
	return code[0] ? 18 : 6;
endfunction

// each word of a list is visited once, in order
function automatic int address_after(int first, int count);
	return first + count;
endfunction

`endif

// ==== test/tb_servo_translator.sv ====
`timescale 1ns/1ps

module tb_servo_translator;

	import servo_pkg::*;
	import move_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int BASE = 25;
	localparam int STEP_CYCLES = 200;
	localparam int PWM_PERIOD = 20;
	localparam int PULSE_LOW = 3;
	localparam int PULSE_HIGH = 8;

	// directed lists first, random list last
	localparam int QUARTER_AT = 25;
	localparam int PRIME_AT = 29;
	localparam int INVALID_AT = 33;
	localparam int PAUSE_AT = 41;
	localparam int RANDOM_AT = 44;
	localparam int RAND_LEN = 20;
	localparam int MEM_DEPTH = RANDOM_AT + RAND_LEN - BASE;

	logic clk;
	logic rst;
	logic enable;
	logic [3:0] dmem_out;
	logic [31:0] address;
	logic servo1, servo2, servo3, servo4;
	logic servo_t, servo_l, servo_b, servo_r;
	logic [7:0] outs;

	logic [3:0] mem [MEM_DEPTH];
	servo_pos_t exp_q[$];
	servo_pos_t frame_q[$];
	servo_pos_t model_pos;
	logic frozen;
	int checks = 0;
	int errors = 0;
	int frames_checked = 0;
	int watchdog_cycles = 0;
	string chan_names [8] = '{"servo1", "servo2", "servo3", "servo4",
		"servo_t", "servo_l", "servo_b", "servo_r"};

	`include "tb_servo_model.svh"

	servo_translator #(
		.ADDR_BASE(32'(BASE)),
		.STEP_CYCLES(27'(STEP_CYCLES)),
		.PWM_PERIOD(20'(PWM_PERIOD)),
		.PULSE_LOW(20'(PULSE_LOW)),
		.PULSE_HIGH(20'(PULSE_HIGH))
	) i_dut (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.dmem_out(dmem_out),
		.address(address),
		.servo1(servo1),
		.servo2(servo2),
		.servo3(servo3),
		.servo4(servo4),
		.servo_t(servo_t),
		.servo_l(servo_l),
		.servo_b(servo_b),
		.servo_r(servo_r)
	);

	// bit i lines up with the servo_pos_t index
	assign outs = {servo_r, servo_b, servo_l, servo_t, servo4, servo3, servo2, servo1};

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(negedge clk) begin
		dmem_out <= read_word(address);
	end

	function automatic logic [3:0] read_word(logic [31:0] a);
		// beyond the loaded lists the memory reads as an invalid code
		if (a >= BASE && a < BASE + MEM_DEPTH) begin
			return mem[a - BASE];
		end
		return 4'hf;
	endfunction

	function automatic logic [31:0] xorshift(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic compare_value(string what, logic [31:0] got, logic [31:0] expected);
		checks++;
		assert (got == expected) else begin
			$display("** Error: %s = 0x%0h, expected 0x%0h", what, got, expected);
			errors++;
		end
	endtask

	task automatic queue_codes(int first, int count);
		int a;
		int s;
		logic [3:0] code;
		for (a = first; a < first + count; a++) begin
			code = read_word(a);
			for (s = 0; s < steps_in_code(code); s++) begin
				model_pos = next_position(face_of_code(code), s % 6, model_pos);
				exp_q.push_back(model_pos);
			end
		end
	endtask

	// enable until the end address is reached, then let the last frames drain
	task automatic finish_codes(int last);
		enable = 1'b1;
		do @(negedge clk); while (address < last);
		enable = 1'b0;
		while (exp_q.size() != 0) @(negedge clk);
		compare_value("address", address, last);
	endtask

	task automatic run_codes(int first, int count);
		queue_codes(first, count);
		finish_codes(address_after(first, count));
	endtask

	task automatic report_test(int num, string name, int errs_at);
		if (errors == errs_at) begin
			$display("test %0d, %s: ok", num, name);
		end else begin
			$display("test %0d, %s: %0d errors", num, name, errors - errs_at);
		end
	endtask

	// high time of every channel per frame, turned back into position bits
	initial begin : measure_frames
		int high [8];
		servo_pos_t f;
		int i;
		do @(posedge clk); while (rst !== 1'b0);
		forever begin
			for (i = 0; i < 8; i++) begin
				high[i] = 0;
			end
			repeat (PWM_PERIOD) begin
				@(negedge clk);
				for (i = 0; i < 8; i++) begin
					if (outs[i]) begin
						high[i]++;
					end
				end
			end
			for (i = 0; i < 8; i++) begin
				checks++;
				assert (high[i] == pulse_width_for(1'b1) || high[i] == pulse_width_for(1'b0))
				else begin
					$display("** Error: %s high time = 0x%0h, expected 0x%0h or 0x%0h",
						chan_names[i], high[i], pulse_width_for(1'b1), pulse_width_for(1'b0));
					errors++;
				end
				f[i] = (high[i] == pulse_width_for(1'b1));
			end
			frame_q.push_back(f);
		end
	end

	// every change of position must be the next expected step
	initial begin : compare_frames
		servo_pos_t f;
		servo_pos_t last_pos;
		last_pos = REST_POS;
		forever begin
			@(negedge clk);
			while (frame_q.size() > 0) begin
				f = frame_q.pop_front();
				frames_checked++;
				if (f != last_pos) begin
					checks++;
					assert (!frozen && exp_q.size() > 0) else begin
						$display("Error: servo positions changed to 0x%0h with no step due", f);
						errors++;
					end
					if (!frozen && exp_q.size() > 0) begin
						compare_value("servo_pos", f, exp_q.pop_front());
					end
					last_pos = f;
				end
			end
		end
	end

	initial begin : watchdog
		wait (watchdog_cycles != 0);
		repeat (watchdog_cycles) @(posedge clk);
		$display("Error: timeout, the tests did not finish in %0d cycles", watchdog_cycles);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin : stimulus
		int i;
		int total;
		int errs_at;
		logic [31:0] rng;
		logic moved;
		clk = 1'b0;
		rst = 1'b1;
		enable = 1'b0;
		dmem_out = 4'hf;
		frozen = 1'b0;
		model_pos = REST_POS;
		for (i = 0; i < 4; i++) begin
			mem[QUARTER_AT - BASE + i] = 4'(2 * i);
			mem[PRIME_AT - BASE + i] = 4'(2 * i + 1);
		end
		for (i = 0; i < 8; i++) begin
			mem[INVALID_AT - BASE + i] = 4'(8 + i);
		end
		mem[PAUSE_AT - BASE] = CODE_R;
		mem[PAUSE_AT - BASE + 1] = CODE_U;
		mem[PAUSE_AT - BASE + 2] = CODE_D;
		rng = 32'd77;
		for (i = 0; i < RAND_LEN; i++) begin
			rng = xorshift(rng);
			mem[RANDOM_AT - BASE + i] = rng[3:0];
		end
		// each move may wait a whole step for its first tick, plus the holds
		total = 15;
		for (i = 0; i < MEM_DEPTH; i++) begin
			total += steps_in_code(mem[i]) + 1;
		end
		watchdog_cycles = total * STEP_CYCLES;

		repeat (3) begin
			@(negedge clk);
			compare_value("servo outputs in reset", 32'(outs), 32'h0);
		end
		rst = 1'b0;

		errs_at = errors;
		@(negedge clk);
		compare_value("address", address, BASE);
		frozen = 1'b1;
		repeat (2 * STEP_CYCLES) @(negedge clk);
		frozen = 1'b0;
		compare_value("address", address, BASE);
		checks++;
		assert (frames_checked > 0) else begin
			$display("Error: no servo frame was decoded after reset");
			errors++;
		end
		report_test(1, "reset and rest position", errs_at);

		errs_at = errors;
		for (i = 0; i < 4; i++) begin
			run_codes(QUARTER_AT + i, 1);
		end
		report_test(2, "quarter turns", errs_at);

		errs_at = errors;
		run_codes(PRIME_AT, 4);
		report_test(3, "prime moves", errs_at);

		errs_at = errors;
		run_codes(INVALID_AT, 8);
		report_test(4, "invalid codes", errs_at);

		// enable drops once the first of three quarter turns has begun
		errs_at = errors;
		queue_codes(PAUSE_AT, 3);
		enable = 1'b1;
		while (exp_q.size() == 18) @(negedge clk);
		enable = 1'b0;
		while (address != PAUSE_AT + 1 || exp_q.size() != 12) @(negedge clk);
		frozen = 1'b1;
		moved = 1'b0;
		repeat (3 * STEP_CYCLES) begin
			@(negedge clk);
			if (address != PAUSE_AT + 1) begin
				moved = 1'b1;
			end
		end
		frozen = 1'b0;
		checks++;
		assert (!moved) else begin
			$display("Error: address moved while enable was low");
			errors++;
		end
		finish_codes(address_after(PAUSE_AT, 3));
		report_test(5, "enable pause and resume", errs_at);

		errs_at = errors;
		run_codes(RANDOM_AT, RAND_LEN);
		report_test(6, "random list", errs_at);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== rtl/servo_translator.sv ====
`timescale 1ns/1ps

module servo_translator #(
	parameter logic [move_pkg::ADDR_W-1:0] ADDR_BASE = move_pkg::DEF_ADDR_BASE,
	parameter logic [26:0] STEP_CYCLES = servo_pkg::DEF_STEP_CYCLES,
	parameter logic [19:0] PWM_PERIOD = servo_pkg::DEF_PWM_PERIOD,
	parameter logic [19:0] PULSE_LOW = servo_pkg::DEF_PULSE_LOW,
	parameter logic [19:0] PULSE_HIGH = servo_pkg::DEF_PULSE_HIGH
) (
	input logic clk,
	input logic rst,
	input logic enable,
	input move_pkg::move_code_t dmem_out,
	output logic [move_pkg::ADDR_W-1:0] address,
	output logic servo1,
	output logic servo2,
	output logic servo3,
	output logic servo4,
	output logic servo_t,
	output logic servo_l,
	output logic servo_b,
	output logic servo_r
);

	import servo_pkg::*;
	import move_pkg::*;

	face_t move_face;
	logic move_prime;
	logic move_valid;
	logic move_done;
	servo_pos_t servo_pos;

	// memory side: address and decode
	move_fetch #(
		.ADDR_BASE(ADDR_BASE)
	) i_fetch (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.dmem_out(dmem_out),
		.move_done(move_done),
		.address(address),
		.move_face(move_face),
		.move_prime(move_prime),
		.move_valid(move_valid)
	);

	move_sequencer #(
		.STEP_CYCLES(STEP_CYCLES)
	) i_seq (
		.clk(clk),
		.rst(rst),
		.move_face(move_face),
		.move_prime(move_prime),
		.move_valid(move_valid),
		.servo_pos(servo_pos),
		.move_done(move_done)
	);

	servo_pwm #(
		.PWM_PERIOD(PWM_PERIOD),
		.PULSE_LOW(PULSE_LOW),
		.PULSE_HIGH(PULSE_HIGH)
	) i_pwm (
		.clk(clk),
		.rst(rst),
		.servo_pos(servo_pos),
		.servo1(servo1),
		.servo2(servo2),
		.servo3(servo3),
		.servo4(servo4),
		.servo_t(servo_t),
		.servo_l(servo_l),
		.servo_b(servo_b),
		.servo_r(servo_r)
	);

endmodule

// ==== rtl/servo_pwm.sv ====
`timescale 1ns/1ps

module servo_pwm #(
	parameter logic [19:0] PWM_PERIOD = servo_pkg::DEF_PWM_PERIOD,
	parameter logic [19:0] PULSE_LOW = servo_pkg::DEF_PULSE_LOW,
	parameter logic [19:0] PULSE_HIGH = servo_pkg::DEF_PULSE_HIGH
) (
	input logic clk,
	input logic rst,
	input servo_pkg::servo_pos_t servo_pos,
	output logic servo1,
	output logic servo2,
	output logic servo3,
	output logic servo4,
	output logic servo_t,
	output logic servo_l,
	output logic servo_b,
	output logic servo_r
);

	import servo_pkg::*;

	logic [19:0] frame_cnt;
	logic frame_end;
	servo_pos_t pos_q;
	logic [NUM_SERVOS-1:0] pwm;

	assign frame_end = (frame_cnt == PWM_PERIOD - 1'b1);

	// reset parks the count at the last cycle of a frame,
	// so outputs stay low and the first frame follows
	always_ff @(posedge clk) begin
		if (rst) begin
			frame_cnt <= PWM_PERIOD - 1'b1;
		end else if (frame_end) begin
			frame_cnt <= '0;
		end else begin
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

	// positions are taken once per frame
	always_ff @(posedge clk) begin
		if (rst) begin
			pos_q <= REST_POS;
		end else if (frame_end) begin
			pos_q <= servo_pos;
		end
	end

	for (genvar i = 0; i < NUM_SERVOS; i++) begin : g_chan
		assign pwm[i] = (frame_cnt < (pos_q[i] ? PULSE_HIGH : PULSE_LOW));
	end

	assign servo1 = pwm[SLIDE_L];
	assign servo2 = pwm[SLIDE_R];
	assign servo3 = pwm[SLIDE_T];
	assign servo4 = pwm[SLIDE_B];
	assign servo_t = pwm[WRIST_T];
	assign servo_l = pwm[WRIST_L];
	assign servo_b = pwm[WRIST_B];
	assign servo_r = pwm[WRIST_R];

endmodule

// ==== rtl/move_sequencer.sv ====
`timescale 1ns/1ps

module move_sequencer #(
	parameter logic [26:0] STEP_CYCLES = servo_pkg::DEF_STEP_CYCLES
) (
	input logic clk,
	input logic rst,
	input move_pkg::face_t move_face,
	input logic move_prime,
	input logic move_valid,
	output servo_pkg::servo_pos_t servo_pos,
	output logic move_done
);

	import servo_pkg::*;
	import move_pkg::*;

	logic [26:0] tick_cnt;
	logic tick;

	logic busy;
	face_t cur_face;
	logic cur_prime;
	step_idx_t step;
	logic [1:0] turn;

	logic last_step;
	logic last_turn;
	logic start;
	face_t act_face;
	step_idx_t act_step;

	// free-running step timer
	always_ff @(posedge clk) begin
		if (rst) begin
			tick_cnt <= '0;
		end else if (tick) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	assign tick = (tick_cnt == STEP_CYCLES - 1'b1);

	assign last_step = (step == step_idx_t'(STEPS_PER_TURN - 1));
	assign last_turn = !cur_prime || (turn == 2'(TURNS_PRIME - 1));

	// a new move only when idle, and its first step on the same tick
	assign start = tick && !busy && move_valid;

	// step 0 comes straight from the decoder
	assign act_face = busy ? cur_face : move_face;
	assign act_step = busy ? step : step_idx_t'(0);

	// high in the tick cycle of the final step
	assign move_done = tick && busy && last_step && last_turn;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			cur_face <= FACE_L;
			cur_prime <= 1'b0;
			step <= '0;
			turn <= '0;
		end else if (start) begin
			busy <= 1'b1;
			cur_face <= move_face;
			cur_prime <= move_prime;
			step <= step_idx_t'(1);
			turn <= '0;
		end else if (tick && busy) begin
			if (last_step) begin
				step <= '0;
				if (last_turn) begin
					busy <= 1'b0;
				end else begin
					// prime move, go round again
					turn <= turn + 1'b1;
				end
			end else begin
				step <= step + 1'b1;
			end
		end
	end

	// servo positions move only on a tick
	always_ff @(posedge clk) begin
		if (rst) begin
			servo_pos <= REST_POS;
		end else if (tick && (busy || move_valid)) begin
			servo_pos <= step_action(act_face, act_step, servo_pos);
		end
	end

endmodule

// ==== rtl/move_fetch.sv ====
`timescale 1ns/1ps

module move_fetch #(
	parameter logic [move_pkg::ADDR_W-1:0] ADDR_BASE = move_pkg::DEF_ADDR_BASE
) (
	input logic clk,
	input logic rst,
	input logic enable,
	input move_pkg::move_code_t dmem_out,
	input logic move_done,
	output logic [move_pkg::ADDR_W-1:0] address,
	output move_pkg::face_t move_face,
	output logic move_prime,
	output logic move_valid
);

	import move_pkg::*;

	logic code_ok;

	// decode the word at the current address
	always_comb begin
		code_ok = 1'b1;
		move_face = FACE_L;
		move_prime = 1'b0;
		case (dmem_out)
			CODE_L: move_face = FACE_L;
			CODE_LP: begin
				move_face = FACE_L;
				move_prime = 1'b1;
			end
			CODE_R: move_face = FACE_R;
			CODE_RP: begin
				move_face = FACE_R;
				move_prime = 1'b1;
			end
			CODE_D: move_face = FACE_D;
			CODE_DP: begin
				move_face = FACE_D;
				move_prime = 1'b1;
			end
			CODE_U: move_face = FACE_U;
			CODE_UP: begin
				move_face = FACE_U;
				move_prime = 1'b1;
			end
			// 8 to 15 are skipped
			default: code_ok = 1'b0;
		endcase
	end

	assign move_valid = enable && code_ok;

	// move_done always advances, even with enable low,
	// otherwise the finished move would run again
	always_ff @(posedge clk) begin
		if (rst) begin
			address <= ADDR_BASE;
		end else if (move_done || (enable && !code_ok)) begin
			address <= address + 1'b1;
		end
	end

endmodule

// ==== rtl/move_pkg.sv ====
package move_pkg;

	import servo_pkg::*;

	// one move per memory word
	typedef logic [3:0] move_code_t;

	localparam move_code_t CODE_L = 4'd0;
	localparam move_code_t CODE_LP = 4'd1;
	localparam move_code_t CODE_R = 4'd2;
	localparam move_code_t CODE_RP = 4'd3;
	localparam move_code_t CODE_D = 4'd4;
	localparam move_code_t CODE_DP = 4'd5;
	localparam move_code_t CODE_U = 4'd6;
	localparam move_code_t CODE_UP = 4'd7;

	typedef enum logic [1:0] {
		FACE_L,
		FACE_R,
		FACE_D,
		FACE_U
	} face_t;

	localparam int STEPS_PER_TURN = 6;
	// a prime move is three quarter turns
	localparam int TURNS_PRIME = 3;

	typedef logic [2:0] step_idx_t;

	localparam int ADDR_W = 32;
	localparam logic [ADDR_W-1:0] DEF_ADDR_BASE = 32'd25;

	// next servo position after one step of a quarter turn on a face
	function automatic servo_pos_t step_action(face_t face, step_idx_t step, servo_pos_t pos);
		servo_pos_t nxt;
		int slide;
		int wrist;
		int cross_a;
		int cross_b;
		nxt = pos;
		// left and right turn under top/bottom, down and up under left/right
		case (face)
			FACE_L: begin
				slide = SLIDE_L;
				wrist = WRIST_L;
				cross_a = SLIDE_T;
				cross_b = SLIDE_B;
			end
			FACE_R: begin
				slide = SLIDE_R;
				wrist = WRIST_R;
				cross_a = SLIDE_T;
				cross_b = SLIDE_B;
			end
			FACE_D: begin
				slide = SLIDE_B;
				wrist = WRIST_B;
				cross_a = SLIDE_L;
				cross_b = SLIDE_R;
			end
			default: begin
				slide = SLIDE_T;
				wrist = WRIST_T;
				cross_a = SLIDE_L;
				cross_b = SLIDE_R;
			end
		endcase
		case (step)
			3'd0: begin
				nxt[cross_a] = 1'b0;
				nxt[cross_b] = 1'b0;
			end
			3'd1: nxt[wrist] = 1'b1;
			3'd2: begin
				nxt[cross_a] = 1'b1;
				nxt[cross_b] = 1'b1;
			end
			3'd3: nxt[slide] = 1'b0;
			3'd4: nxt[wrist] = 1'b0;
			3'd5: nxt[slide] = 1'b1;
			default: nxt = pos;
		endcase
		return nxt;
	endfunction

endpackage

// ==== rtl/servo_pkg.sv ====
package servo_pkg;

	// eight channels: four slides, four wrists
	localparam int NUM_SERVOS = 8;

	// one position bit per channel
	typedef logic [NUM_SERVOS-1:0] servo_pos_t;

	// slides, 1 = extended
	localparam int SLIDE_L = 0;
	localparam int SLIDE_R = 1;
	localparam int SLIDE_T = 2;
	localparam int SLIDE_B = 3;

	// wrists, 1 = turned 90 degrees ccw
	// order follows the servo_t/l/b/r outputs
	localparam int WRIST_T = 4;
	localparam int WRIST_L = 5;
	localparam int WRIST_B = 6;
	localparam int WRIST_R = 7;

	// all slides out, all wrists at rest
	localparam servo_pos_t REST_POS = servo_pos_t'(
		(1 << SLIDE_L) | (1 << SLIDE_R) | (1 << SLIDE_T) | (1 << SLIDE_B)
	);

	// 20 ms frame at 50 MHz
	localparam logic [19:0] DEF_PWM_PERIOD = 20'd1000000;

	// 1 ms and 2 ms pulses
	localparam logic [19:0] DEF_PULSE_LOW = 20'd50000;
	localparam logic [19:0] DEF_PULSE_HIGH = 20'd100000;

	// one step per half second at 50 MHz
	localparam logic [26:0] DEF_STEP_CYCLES = 27'd25000000;

endpackage
